/* hw/vga_pkg.sv */
// vga_pkg: display geometry, colors, sprite constants and shared enum types
`default_nettype none

package vga_pkg;

    // 800x600 @ 60 Hz, 40 MHz pixel clock
    localparam logic [10:0] HOR_PIXELS  = 11'd800;     // active width
    localparam logic [10:0] VER_PIXELS  = 11'd600;     // active height
    localparam logic [10:0] HOR_TOTAL   = 11'd1056;    // full line incl. blanking
    localparam logic [10:0] VER_TOTAL   = 11'd628;     // full frame incl. blanking
    localparam logic [10:0] HSYNC_START = 11'd840;
    localparam logic [10:0] HSYNC_END   = 11'd968;     // 128-pixel pulse
    localparam logic [10:0] VSYNC_START = 11'd601;
    localparam logic [10:0] VSYNC_END   = 11'd605;     // 4-line pulse

    // 12-bit rgb, 4 bits per channel
    localparam logic [11:0] COLOR_BLACK  = 12'h0_0_0;
    localparam logic [11:0] COLOR_TOP    = 12'hf_f_0;  // yellow
    localparam logic [11:0] COLOR_BOTTOM = 12'hf_0_0;  // red
    localparam logic [11:0] COLOR_LEFT   = 12'h0_f_0;  // green
    localparam logic [11:0] COLOR_RIGHT  = 12'h0_0_f;  // blue
    localparam logic [11:0] COLOR_FILL   = 12'h8_8_f;  // bluish gray

    // sprite
    localparam logic [10:0] SPRITE_SIZE = 11'd16;      // square, pixels per side
    localparam logic [11:0] SPRITE_KEY  = 12'hf_0_f;   // magenta = see-through
    localparam int          RAM_AW      = 8;           // 16x16 words

    // host register map, byte addresses
    localparam logic [11:0] ADDR_SPRITE_X = 12'h000;
    localparam logic [11:0] ADDR_SPRITE_Y = 12'h004;
    localparam logic [11:0] ADDR_RAM_BASE = 12'h400;   // 256 words follow

    typedef enum logic {OP_READ, OP_WRITE} ram_op_t;

    typedef enum logic [1:0] {ST_IDLE, ST_RAM_WAIT, ST_WRESP, ST_RRESP} axil_state_t;

    typedef enum logic [1:0] {RESP_OKAY = 2'b00, RESP_SLVERR = 2'b10} axil_resp_t;

endpackage

`default_nettype wire

/* hw/vga_timing.sv */
// vga_timing: 800x600 pixel counters with registered sync and blanking flags
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
    input  logic        clk,
    input  logic        rst,
    output logic [10:0] hcount,
    output logic [10:0] vcount,
    output logic        hsync,
    output logic        vsync,
    output logic        hblnk,
    output logic        vblnk
);

    logic [10:0] hcount_nxt;
    logic [10:0] vcount_nxt;

    always_comb begin
        if (hcount == vga_pkg::HOR_TOTAL - 11'd1) begin          // last pixel of line
            hcount_nxt = '0;
            if (vcount == vga_pkg::VER_TOTAL - 11'd1)              // last line of frame
                vcount_nxt = '0;
            else
                vcount_nxt = vcount + 11'd1;
        end else begin
            hcount_nxt = hcount + 11'd1;
            vcount_nxt = vcount;
        end
    end

    // flags decoded from next count so they line up with the counters
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hsync  <= (hcount_nxt >= vga_pkg::HSYNC_START) && (hcount_nxt < vga_pkg::HSYNC_END);
            vsync  <= (vcount_nxt >= vga_pkg::VSYNC_START) && (vcount_nxt < vga_pkg::VSYNC_END);
            hblnk  <= hcount_nxt >= vga_pkg::HOR_PIXELS;
            vblnk  <= vcount_nxt >= vga_pkg::VER_PIXELS;
        end
    end

    a_count_range: assert property (@(posedge clk) disable iff (rst)
        (hcount < vga_pkg::HOR_TOTAL) && (vcount < vga_pkg::VER_TOTAL))
        else $error("vga_timing: counter past total");

endmodule

`default_nettype wire

/* hw/draw_start_bg.sv */
// draw_start_bg: start-screen background with colored edge lines over a gray fill
`timescale 1ns/1ps
`default_nettype none

module draw_start_bg (
    input  logic        clk,
    input  logic        rst,
    input  logic [10:0] hcount_in,
    input  logic [10:0] vcount_in,
    input  logic        hsync_in,
    input  logic        vsync_in,
    input  logic        hblnk_in,
    input  logic        vblnk_in,
    output logic [10:0] hcount,
    output logic [10:0] vcount,
    output logic        hsync,
    output logic        vsync,
    output logic        hblnk,
    output logic        vblnk,
    output logic [11:0] rgb
);

    logic [11:0] rgb_nxt;

    always_comb begin
        if (vblnk_in || hblnk_in)                                  // outside active area
            rgb_nxt = vga_pkg::COLOR_BLACK;
        else if (vcount_in == '0)                                  // top line wins corners
            rgb_nxt = vga_pkg::COLOR_TOP;
        else if (vcount_in == vga_pkg::VER_PIXELS - 11'd1)
            rgb_nxt = vga_pkg::COLOR_BOTTOM;
        else if (hcount_in == '0)
            rgb_nxt = vga_pkg::COLOR_LEFT;
        else if (hcount_in == vga_pkg::HOR_PIXELS - 11'd1)
            rgb_nxt = vga_pkg::COLOR_RIGHT;
        else
            rgb_nxt = vga_pkg::COLOR_FILL;                         // interior
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            rgb    <= vga_pkg::COLOR_BLACK;
        end else begin
            hcount <= hcount_in;                                   // one-stage delay
            vcount <= vcount_in;
            hsync  <= hsync_in;
            vsync  <= vsync_in;
            hblnk  <= hblnk_in;
            vblnk  <= vblnk_in;
            rgb    <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

/* hw/draw_sprite.sv */
// draw_sprite: overlays a 16x16 color-keyed sprite read from sprite RAM
`timescale 1ns/1ps
`default_nettype none

module draw_sprite (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [10:0]               hcount_in,
    input  logic [10:0]               vcount_in,
    input  logic                      hsync_in,
    input  logic                      vsync_in,
    input  logic                      hblnk_in,
    input  logic                      vblnk_in,
    input  logic [11:0]               rgb_in,
    input  logic [10:0]               sprite_x,
    input  logic [10:0]               sprite_y,
    output logic                      px_req,
    output logic [vga_pkg::RAM_AW-1:0] px_addr,
    input  logic [11:0]               rd_data,
    output logic [10:0]               hcount,
    output logic [10:0]               vcount,
    output logic                      hsync,
    output logic                      vsync,
    output logic [11:0]               rgb
);

    logic [10:0] rel_x;                                            // offset inside box
    logic [10:0] rel_y;
    logic        in_box;
    logic [10:0] hcount_d;                                         // stage 1 copies
    logic [10:0] vcount_d;
    logic        hsync_d;
    logic        vsync_d;
    logic [11:0] rgb_d;
    logic        in_box_d;

    assign rel_x  = hcount_in - sprite_x;
    assign rel_y  = vcount_in - sprite_y;
    assign in_box = (hcount_in >= sprite_x) && (rel_x < vga_pkg::SPRITE_SIZE)
                 && (vcount_in >= sprite_y) && (rel_y < vga_pkg::SPRITE_SIZE)
                 && !hblnk_in && !vblnk_in;

    assign px_req  = in_box;                                       // always granted
    assign px_addr = {rel_y[3:0], rel_x[3:0]};                     // row * 16 + col

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount_d <= '0;
            vcount_d <= '0;
            hsync_d  <= 1'b0;
            vsync_d  <= 1'b0;
            rgb_d    <= vga_pkg::COLOR_BLACK;
            in_box_d <= 1'b0;
            hcount   <= '0;
            vcount   <= '0;
            hsync    <= 1'b0;
            vsync    <= 1'b0;
            rgb      <= vga_pkg::COLOR_BLACK;
        end else begin
            hcount_d <= hcount_in;                                 // stage 1, RAM read in flight
            vcount_d <= vcount_in;
            hsync_d  <= hsync_in;
            vsync_d  <= vsync_in;
            rgb_d    <= rgb_in;
            in_box_d <= in_box;
            hcount   <= hcount_d;                                  // stage 2, rd_data valid
            vcount   <= vcount_d;
            hsync    <= hsync_d;
            vsync    <= vsync_d;
            if (in_box_d && (rd_data != vga_pkg::SPRITE_KEY))
                rgb <= rd_data;                                    // opaque sprite pixel
            else
                rgb <= rgb_d;                                      // background shows
        end
    end

endmodule

`default_nettype wire

/* hw/sprite_ram.sv */
// sprite_ram: single-port 256x12 RAM with synchronous read and write
`timescale 1ns/1ps
`default_nettype none

module sprite_ram (
    input  logic                      clk,
    input  logic                      en,
    input  logic                      we,
    input  logic [vga_pkg::RAM_AW-1:0] addr,
    input  logic [11:0]               wdata,
    output logic [11:0]               rdata
);

    logic [11:0] mem [0:(1 << vga_pkg::RAM_AW) - 1];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we)
                mem[addr] <= wdata;
            rdata <= mem[addr];                                    // read-first, next cycle
        end
    end

endmodule

`default_nettype wire

/* hw/ram_arbiter.sv */
// ram_arbiter: fixed-priority sharing of sprite RAM, painter ahead of host
`timescale 1ns/1ps
`default_nettype none

module ram_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      px_req,
    input  logic [vga_pkg::RAM_AW-1:0] px_addr,
    input  logic                      host_req,
    input  vga_pkg::ram_op_t          host_op,
    input  logic [vga_pkg::RAM_AW-1:0] host_addr,
    input  logic [11:0]               host_wdata,
    output logic                      host_ack,
    output logic                      ram_en,
    output logic                      ram_we,
    output logic [vga_pkg::RAM_AW-1:0] ram_addr,
    output logic [11:0]               ram_wdata
);

    logic ack_q;                                                   // ack given last cycle

    // host goes only when the painter is idle, once per request
    assign host_ack  = host_req && !px_req && !ack_q;

    assign ram_en    = px_req || host_ack;
    assign ram_we    = host_ack && (host_op == vga_pkg::OP_WRITE); // painter never writes
    assign ram_addr  = px_req ? px_addr : host_addr;
    assign ram_wdata = host_wdata;

    always_ff @(posedge clk) begin
        if (rst)
            ack_q <= 1'b0;
        else
            ack_q <= host_ack;                                     // blocks a lingering req
    end

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        host_req && !host_ack |=> host_req && $stable(host_op)
                                  && $stable(host_addr) && $stable(host_wdata))
        else $error("ram_arbiter: host request dropped or changed before ack");

endmodule

`default_nettype wire

/* hw/axil_regs.sv */
// axil_regs: AXI4-Lite slave for sprite position and the sprite RAM window
`timescale 1ns/1ps
`default_nettype none

module axil_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [11:0]               s_awaddr,
    input  logic                      s_awvalid,
    output logic                      s_awready,
    input  logic [31:0]               s_wdata,
    input  logic                      s_wvalid,
    output logic                      s_wready,
    output logic [1:0]                s_bresp,
    output logic                      s_bvalid,
    input  logic                      s_bready,
    input  logic [11:0]               s_araddr,
    input  logic                      s_arvalid,
    output logic                      s_arready,
    output logic [31:0]               s_rdata,
    output logic [1:0]                s_rresp,
    output logic                      s_rvalid,
    input  logic                      s_rready,
    output logic [10:0]               sprite_x,
    output logic [10:0]               sprite_y,
    output logic                      host_req,
    output vga_pkg::ram_op_t          host_op,
    output logic [vga_pkg::RAM_AW-1:0] host_addr,
    output logic [11:0]               host_wdata,
    input  logic                      host_ack,
    input  logic [11:0]               ram_rdata
);

    vga_pkg::axil_state_t state;
    logic                 wr_go;                                   // write accepted now
    logic                 rd_go;                                   // read accepted now
    logic [11:0]          sel_addr;
    logic                 hit_x;
    logic                 hit_y;
    logic                 hit_ram;
    logic                 rd_pend;                                 // RAM word arrives next

    assign wr_go     = (state == vga_pkg::ST_IDLE) && s_awvalid && s_wvalid;
    assign rd_go     = (state == vga_pkg::ST_IDLE) && s_arvalid && !wr_go; // write first
    assign s_awready = wr_go;
    assign s_wready  = wr_go;
    assign s_arready = rd_go;
    assign host_req  = (state == vga_pkg::ST_RAM_WAIT);

    assign sel_addr = wr_go ? s_awaddr : s_araddr;
    assign hit_x    = sel_addr == vga_pkg::ADDR_SPRITE_X;
    assign hit_y    = sel_addr == vga_pkg::ADDR_SPRITE_Y;
    assign hit_ram  = sel_addr[11:10] == vga_pkg::ADDR_RAM_BASE[11:10]; // 0x400..0x7ff

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= vga_pkg::ST_IDLE;
            s_bvalid <= 1'b0;
            s_rvalid <= 1'b0;
            s_bresp  <= vga_pkg::RESP_OKAY;
            s_rresp  <= vga_pkg::RESP_OKAY;
            sprite_x <= '0;
            sprite_y <= '0;
            rd_pend  <= 1'b0;
            host_op  <= vga_pkg::OP_READ;
        end else begin
            case (state)
                vga_pkg::ST_IDLE: begin
                    if (wr_go) begin
                        s_bresp <= vga_pkg::RESP_OKAY;
                        if (hit_ram) begin
                            host_op <= vga_pkg::OP_WRITE;
                            state   <= vga_pkg::ST_RAM_WAIT;
                        end else begin
                            if (hit_x)
                                sprite_x <= s_wdata[10:0];
                            else if (hit_y)
                                sprite_y <= s_wdata[10:0];
                            else
                                s_bresp <= vga_pkg::RESP_SLVERR;   // unmapped
                            s_bvalid <= 1'b1;
                            state    <= vga_pkg::ST_WRESP;
                        end
                    end else if (rd_go) begin
                        s_rresp <= vga_pkg::RESP_OKAY;
                        if (hit_ram) begin
                            host_op <= vga_pkg::OP_READ;
                            state   <= vga_pkg::ST_RAM_WAIT;
                        end else begin
                            if (!hit_x && !hit_y)
                                s_rresp <= vga_pkg::RESP_SLVERR;
                            s_rvalid <= 1'b1;
                            state    <= vga_pkg::ST_RRESP;
                        end
                    end
                end
                vga_pkg::ST_RAM_WAIT: begin
                    if (host_ack) begin                            // painter idle this cycle
                        if (host_op == vga_pkg::OP_WRITE) begin
                            s_bvalid <= 1'b1;
                            state    <= vga_pkg::ST_WRESP;
                        end else begin
                            rd_pend <= 1'b1;
                            state   <= vga_pkg::ST_RRESP;
                        end
                    end
                end
                vga_pkg::ST_WRESP: begin
                    if (s_bready) begin
                        s_bvalid <= 1'b0;
                        state    <= vga_pkg::ST_IDLE;
                    end
                end
                default: begin                                     // ST_RRESP
                    if (rd_pend) begin
                        rd_pend  <= 1'b0;
                        s_rvalid <= 1'b1;
                    end else if (s_rready) begin
                        s_rvalid <= 1'b0;
                        state    <= vga_pkg::ST_IDLE;
                    end
                end
            endcase
        end
    end

    // payload registers, no reset
    always_ff @(posedge clk) begin
        if (wr_go || rd_go) begin
            host_addr  <= sel_addr[vga_pkg::RAM_AW+1:2];           // word index
            host_wdata <= s_wdata[11:0];
            if (hit_x)
                s_rdata <= {21'd0, sprite_x};
            else if (hit_y)
                s_rdata <= {21'd0, sprite_y};
            else
                s_rdata <= '0;                                     // unmapped reads zero
        end else if (rd_pend) begin
            s_rdata <= {20'd0, ram_rdata};                         // one cycle after ack
        end
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        s_bvalid && !s_bready |=> s_bvalid)
        else $error("axil_regs: BVALID dropped before BREADY");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
        else $error("axil_regs: RVALID or RDATA changed before RREADY");

endmodule

`default_nettype wire

/* hw/vga_top.sv */
// vga_top: display pipeline with sprite RAM shared between painter and AXI4-Lite host
`timescale 1ns/1ps
`default_nettype none

module vga_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [11:0] s_awaddr,
    input  logic        s_awvalid,
    output logic        s_awready,
    input  logic [31:0] s_wdata,
    input  logic        s_wvalid,
    output logic        s_wready,
    output logic [1:0]  s_bresp,
    output logic        s_bvalid,
    input  logic        s_bready,
    input  logic [11:0] s_araddr,
    input  logic        s_arvalid,
    output logic        s_arready,
    output logic [31:0] s_rdata,
    output logic [1:0]  s_rresp,
    output logic        s_rvalid,
    input  logic        s_rready,
    output logic [10:0] hcount_out,
    output logic [10:0] vcount_out,
    output logic        hsync_out,
    output logic        vsync_out,
    output logic [11:0] rgb_out
);

    logic [10:0]               tim_hcount;                         // timing -> background
    logic [10:0]               tim_vcount;
    logic                      tim_hsync;
    logic                      tim_vsync;
    logic                      tim_hblnk;
    logic                      tim_vblnk;
    logic [10:0]               bg_hcount;                          // background -> sprite
    logic [10:0]               bg_vcount;
    logic                      bg_hsync;
    logic                      bg_vsync;
    logic                      bg_hblnk;
    logic                      bg_vblnk;
    logic [11:0]               bg_rgb;
    logic [10:0]               sprite_x;
    logic [10:0]               sprite_y;
    logic                      px_req;
    logic [vga_pkg::RAM_AW-1:0] px_addr;
    logic                      host_req;
    vga_pkg::ram_op_t          host_op;
    logic [vga_pkg::RAM_AW-1:0] host_addr;
    logic [11:0]               host_wdata;
    logic                      host_ack;
    logic                      ram_en;
    logic                      ram_we;
    logic [vga_pkg::RAM_AW-1:0] ram_addr;
    logic [11:0]               ram_wdata;
    logic [11:0]               ram_rdata;                          // to painter and host

    vga_timing u_vga_timing (
        .clk, .rst,
        .hcount(tim_hcount), .vcount(tim_vcount),
        .hsync(tim_hsync), .vsync(tim_vsync),
        .hblnk(tim_hblnk), .vblnk(tim_vblnk)
    );

    draw_start_bg u_draw_start_bg (
        .clk, .rst,
        .hcount_in(tim_hcount), .vcount_in(tim_vcount),
        .hsync_in(tim_hsync), .vsync_in(tim_vsync),
        .hblnk_in(tim_hblnk), .vblnk_in(tim_vblnk),
        .hcount(bg_hcount), .vcount(bg_vcount),
        .hsync(bg_hsync), .vsync(bg_vsync),
        .hblnk(bg_hblnk), .vblnk(bg_vblnk),
        .rgb(bg_rgb)
    );

    draw_sprite u_draw_sprite (
        .clk, .rst,
        .hcount_in(bg_hcount), .vcount_in(bg_vcount),
        .hsync_in(bg_hsync), .vsync_in(bg_vsync),
        .hblnk_in(bg_hblnk), .vblnk_in(bg_vblnk),
        .rgb_in(bg_rgb),
        .sprite_x, .sprite_y,
        .px_req, .px_addr, .rd_data(ram_rdata),
        .hcount(hcount_out), .vcount(vcount_out),
        .hsync(hsync_out), .vsync(vsync_out),
        .rgb(rgb_out)
    );

    sprite_ram u_sprite_ram (
        .clk,
        .en(ram_en), .we(ram_we), .addr(ram_addr),
        .wdata(ram_wdata), .rdata(ram_rdata)
    );

    ram_arbiter u_ram_arbiter (
        .clk, .rst,
        .px_req, .px_addr,
        .host_req, .host_op, .host_addr, .host_wdata, .host_ack,
        .ram_en, .ram_we, .ram_addr, .ram_wdata
    );

    axil_regs u_axil_regs (
        .clk, .rst,
        .s_awaddr, .s_awvalid, .s_awready,
        .s_wdata, .s_wvalid, .s_wready,
        .s_bresp, .s_bvalid, .s_bready,
        .s_araddr, .s_arvalid, .s_arready,
        .s_rdata, .s_rresp, .s_rvalid, .s_rready,
        .sprite_x, .sprite_y,
        .host_req, .host_op, .host_addr, .host_wdata, .host_ack,
        .ram_rdata
    );

endmodule

`default_nettype wire

/* verification/vga_tb.sv */
// vga_tb: table-driven testbench for the VGA pipeline and its AXI4-Lite sprite port
`timescale 1ns/1ps
`default_nettype none

module vga_tb;

    // axi count: 256 ram writes, 256 ram reads, x/y write+read, 2 unmapped, 2 moves
    localparam int N_AXI   = 520;
    localparam int FRAME   = int'(vga_pkg::VER_TOTAL) * int'(vga_pkg::HOR_TOTAL);
    localparam int LIMIT   = 3 * FRAME + 20 * N_AXI;       // ram waits end in ST_WRESP/ST_RRESP
    localparam int HP      = int'(vga_pkg::HOR_PIXELS);
    localparam int VP      = int'(vga_pkg::VER_PIXELS);
    localparam int N_PROBE = 32;
    localparam int N_PASS1 = 24;                           // first pass, sprite at 200,300

    localparam int K_BLACK  = 0;                           // expected kind of pixel
    localparam int K_TOP    = 1;
    localparam int K_BOTTOM = 2;
    localparam int K_LEFT   = 3;
    localparam int K_RIGHT  = 4;
    localparam int K_FILL   = 5;
    localparam int K_SPRITE = 6;                           // word or background if keyed

    logic        clk;
    logic        rst;
    logic [11:0] s_awaddr;
    logic        s_awvalid;
    logic        s_awready;
    logic [31:0] s_wdata;
    logic        s_wvalid;
    logic        s_wready;
    logic [1:0]  s_bresp;
    logic        s_bvalid;
    logic        s_bready;
    logic [11:0] s_araddr;
    logic        s_arvalid;
    logic        s_arready;
    logic [31:0] s_rdata;
    logic [1:0]  s_rresp;
    logic        s_rvalid;
    logic        s_rready;
    logic [10:0] hcount_out;
    logic [10:0] vcount_out;
    logic        hsync_out;
    logic        vsync_out;
    logic [11:0] rgb_out;

    logic [11:0] sprite_mem [0:255];                       // model of sprite RAM
    int          spr_x = 0;                                // model of sprite position
    int          spr_y = 0;
    int          cycle_count = 0;

    // hcount, vcount, kind; raster order inside each pass
    int probe_tab [0:N_PROBE-1][0:2] = '{
        '{0, 0, K_TOP}, '{400, 0, K_TOP}, '{799, 0, K_TOP}, '{900, 0, K_BLACK},
        '{820, 10, K_BLACK}, '{200, 299, K_FILL},
        '{0, 300, K_LEFT}, '{199, 300, K_FILL}, '{200, 300, K_SPRITE},
        '{203, 300, K_SPRITE}, '{210, 300, K_SPRITE}, '{216, 300, K_FILL},
        '{799, 300, K_RIGHT}, '{204, 302, K_SPRITE}, '{207, 308, K_SPRITE},
        '{214, 315, K_SPRITE}, '{215, 315, K_SPRITE}, '{200, 316, K_FILL},
        '{400, 400, K_FILL}, '{0, 599, K_BOTTOM}, '{400, 599, K_BOTTOM},
        '{799, 599, K_BOTTOM}, '{10, 610, K_BLACK}, '{400, 620, K_BLACK},
        '{0, 99, K_LEFT}, '{0, 100, K_SPRITE}, '{3, 100, K_SPRITE}, '{15, 100, K_SPRITE},
        '{16, 100, K_FILL}, '{0, 105, K_SPRITE}, '{0, 115, K_SPRITE}, '{0, 116, K_LEFT}
    };

    vga_top UUT (
        .clk, .rst,
        .s_awaddr, .s_awvalid, .s_awready,
        .s_wdata, .s_wvalid, .s_wready,
        .s_bresp, .s_bvalid, .s_bready,
        .s_araddr, .s_arvalid, .s_arready,
        .s_rdata, .s_rresp, .s_rvalid, .s_rready,
        .hcount_out, .vcount_out, .hsync_out, .vsync_out, .rgb_out
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                            // 20 ns period
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("STATUS: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_rgb(input string name, input logic [11:0] got,
                             input logic [11:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "color mismatch");
        end
    endtask

    task automatic check_data(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_resp(input string name, input vga_pkg::axil_resp_t got,
                              input vga_pkg::axil_resp_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "flag mismatch");
        end
    endtask

    // sync pulses line up with the output counters
    always @(negedge clk) begin
        if (rst === 1'b0) begin
            check_bit("hsync_out", hsync_out,
                      hcount_out >= vga_pkg::HSYNC_START && hcount_out < vga_pkg::HSYNC_END);
            check_bit("vsync_out", vsync_out,
                      vcount_out >= vga_pkg::VSYNC_START && vcount_out < vga_pkg::VSYNC_END);
        end
    end

    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                              output vga_pkg::axil_resp_t resp);
        @(posedge clk);
        #2;
        s_awaddr  = addr;
        s_wdata   = data;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        s_bready  = 1'b1;                                  // ready before bvalid
        do @(negedge clk); while (!s_awready);             // accepted at next edge
        check_bit("s_wready", s_wready, 1'b1);             // raised with awready
        @(posedge clk);
        #2;
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        do @(negedge clk); while (!s_bvalid);              // ram writes may wait on painter
        resp = vga_pkg::axil_resp_t'(s_bresp);
        @(posedge clk);
        #2;
        s_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data,
                             output vga_pkg::axil_resp_t resp);
        @(posedge clk);
        #2;
        s_araddr  = addr;
        s_arvalid = 1'b1;
        s_rready  = 1'b1;
        do @(negedge clk); while (!s_arready);
        @(posedge clk);
        #2;
        s_arvalid = 1'b0;
        do @(negedge clk); while (!s_rvalid);
        data = s_rdata;
        resp = vga_pkg::axil_resp_t'(s_rresp);
        @(posedge clk);
        #2;
        s_rready = 1'b0;
    endtask

    // blanking black, then top, bottom, left, right lines, else gray
    function automatic logic [11:0] background_color(input int h, input int v);
        if (h >= HP || v >= VP)
            return vga_pkg::COLOR_BLACK;
        else if (v == 0)
            return vga_pkg::COLOR_TOP;
        else if (v == VP - 1)
            return vga_pkg::COLOR_BOTTOM;
        else if (h == 0)
            return vga_pkg::COLOR_LEFT;
        else if (h == HP - 1)
            return vga_pkg::COLOR_RIGHT;
        else
            return vga_pkg::COLOR_FILL;
    endfunction

    function automatic logic [11:0] expected_rgb(input int h, input int v, input int kind);
        logic [7:0]  idx;
        logic [11:0] word;
        case (kind)
            K_BLACK:  return vga_pkg::COLOR_BLACK;
            K_TOP:    return vga_pkg::COLOR_TOP;
            K_BOTTOM: return vga_pkg::COLOR_BOTTOM;
            K_LEFT:   return vga_pkg::COLOR_LEFT;
            K_RIGHT:  return vga_pkg::COLOR_RIGHT;
            K_FILL:   return vga_pkg::COLOR_FILL;
            default: begin
                idx  = 8'((v - spr_y) * 16 + (h - spr_x));    // row-major word
                word = sprite_mem[idx];
                if (word == vga_pkg::SPRITE_KEY)
                    return background_color(h, v);            // see-through
                return word;
            end
        endcase
    endfunction

    // wait for each table pixel at the output, compare its color
    task automatic run_probes(input int first, input int last);
        for (int i = first; i < last; i++) begin
            do @(negedge clk);
            while (int'(hcount_out) != probe_tab[i][0] || int'(vcount_out) != probe_tab[i][1]);
            check_rgb($sformatf("rgb_out(%0d,%0d)", probe_tab[i][0], probe_tab[i][1]),
                      rgb_out, expected_rgb(probe_tab[i][0], probe_tab[i][1], probe_tab[i][2]));
        end
    endtask

    initial begin
        vga_pkg::axil_resp_t resp;
        logic [31:0]         rdata;
        rst       = 1'b1;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        void'($urandom(22));
        for (int i = 0; i < 256; i++) begin
            if (i % 7 == 3)
                sprite_mem[i] = vga_pkg::SPRITE_KEY;       // sprinkle keyed pixels
            else
                sprite_mem[i] = 12'($urandom);
        end
        repeat (10) @(posedge clk);
        #2 rst = 1'b0;

        // sprite still at 0,0 so the painter competes on the first lines
        for (int i = 0; i < 256; i++) begin
            axil_write(vga_pkg::ADDR_RAM_BASE + 12'(i * 4), {20'd0, sprite_mem[i]}, resp);
            check_resp("s_bresp", resp, vga_pkg::RESP_OKAY);
        end
        for (int i = 0; i < 256; i++) begin
            axil_read(vga_pkg::ADDR_RAM_BASE + 12'(i * 4), rdata, resp);
            check_resp("s_rresp", resp, vga_pkg::RESP_OKAY);
            check_data("s_rdata", rdata, {20'd0, sprite_mem[i]});
        end

        axil_write(vga_pkg::ADDR_SPRITE_X, 32'd200, resp);
        check_resp("s_bresp", resp, vga_pkg::RESP_OKAY);
        axil_write(vga_pkg::ADDR_SPRITE_Y, 32'd300, resp);
        check_resp("s_bresp", resp, vga_pkg::RESP_OKAY);
        spr_x = 200;
        spr_y = 300;
        axil_read(vga_pkg::ADDR_SPRITE_X, rdata, resp);
        check_resp("s_rresp", resp, vga_pkg::RESP_OKAY);
        check_data("s_rdata", rdata, 32'd200);
        axil_read(vga_pkg::ADDR_SPRITE_Y, rdata, resp);
        check_resp("s_rresp", resp, vga_pkg::RESP_OKAY);
        check_data("s_rdata", rdata, 32'd300);

        axil_write(12'h008, 32'hdead_beef, resp);          // hole between regs and window
        check_resp("s_bresp", resp, vga_pkg::RESP_SLVERR);
        axil_read(12'h800, rdata, resp);                   // past the ram window
        check_resp("s_rresp", resp, vga_pkg::RESP_SLVERR);
        check_data("s_rdata", rdata, 32'd0);

        run_probes(0, N_PASS1);

        // onto the left edge line
        axil_write(vga_pkg::ADDR_SPRITE_X, 32'd0, resp);
        check_resp("s_bresp", resp, vga_pkg::RESP_OKAY);
        axil_write(vga_pkg::ADDR_SPRITE_Y, 32'd100, resp);
        check_resp("s_bresp", resp, vga_pkg::RESP_OKAY);
        spr_x = 0;
        spr_y = 100;
        run_probes(N_PASS1, N_PROBE);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
hw/vga_pkg.sv
hw/vga_timing.sv
hw/draw_start_bg.sv
hw/draw_sprite.sv
hw/sprite_ram.sv
hw/ram_arbiter.sv
hw/axil_regs.sv
hw/vga_top.sv
verification/vga_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the VGA testbench with Verilator, run it, judge the result from the log

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f project.f --top-module vga_tb -o vga_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/vga_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "pass line not found in $LOG"
    exit 1
fi
